/* src/sensor_config.svh */
`ifndef SENSOR_CONFIG_SVH
`define SENSOR_CONFIG_SVH

// command bus word layout
`define SENS_ADDR_BITS        16      // command address width
`define SENS_DATA_BITS        32      // command data width

// register address map
`define SENS_GROUP_ADDR       16'h400 // channel 0 base
`define SENS_BASE_INC         16'h040 // per-channel stride
`define SENS_MODE_RADDR       0       // mode word, channel enable
`define SENS_SYNC_MULT_RADDR  'h6     // frames to combine minus 1
`define SENS_SYNC_LATE_RADDR  'h7     // lines before late sof
`define SENS_STATUS_RADDR     'h9     // any write here asks for status

// status packet addressing
`define SENS_STATUS_BASE      8'h21   // address byte of channel 0
`define SENS_STATUS_INC       2       // address byte stride
`define SENS_STATUS_BYTES     4       // addr, fn lo, fn hi, flags

// mode word fields
`define SENS_CHN_EN_BIT       8       // channel enable position

// frame sync counters
`define SENS_SYNC_BITS        16      // combine, line and frame counters
`define SENS_SYNC_LATE_DFLT   15      // late line count after reset

// channel count, power of two
`define SENS_NUM_CHN          4

`endif

/* src/sensor_pkg.sv */
`include "sensor_config.svh"

package sensor_pkg;

    // one complete write from the byte-serial bus
    typedef struct packed {
        logic [`SENS_ADDR_BITS-1:0] addr; // AH:AL
        logic [`SENS_DATA_BITS-1:0] data; // D3:D0
    } cmd_word_t;

    // mode register view of the data word
    typedef struct packed {
        logic [`SENS_DATA_BITS-`SENS_CHN_EN_BIT-2:0] rsvd_hi; // dropped mode bits
        logic                                        chn_en;  // bit 8
        logic [`SENS_CHN_EN_BIT-1:0]                 rsvd_lo; // ex histogram bits
    } mode_view_t;

    // count register view, low half only
    typedef struct packed {
        logic [`SENS_DATA_BITS-`SENS_SYNC_BITS-1:0] unused;
        logic [`SENS_SYNC_BITS-1:0]                 count;   // mult or late lines
    } sync_view_t;

    // same written word, decoded by target address
    typedef union packed {
        mode_view_t mode;
        sync_view_t sync;
    } cmd_data_u;

    // per-channel configuration, regs -> frame sync
    typedef struct packed {
        logic                       chn_en;     // channel enable
        logic [`SENS_SYNC_BITS-1:0] frame_mult; // sensor frames per output minus 1
        logic [`SENS_SYNC_BITS-1:0] late_lines; // hact falls before sof_late
    } cfg_t;

    typedef logic [7:0] status_byte_t; // one status bus byte

endpackage

/* src/sensor_cfg_if.sv */
`timescale 1ns/1ps
`include "sensor_config.svh"

// joins one register block to its frame synchronizer
interface sensor_cfg_if;
    import sensor_pkg::*;

    cfg_t                       conf;      // enable, combine count, late lines
    logic [`SENS_SYNC_BITS-1:0] frame_num; // output frame counter

    // register side owns the configuration
    modport regs (
        output conf,
        input  frame_num
    );

    // synchronizer side reports frames back
    modport sync (
        input  conf,
        output frame_num
    );

endinterface

/* src/cmd_deser.sv */
`timescale 1ns/1ps
`include "sensor_config.svh"

module cmd_deser (
    input  logic                  mclk,
    input  logic                  rst,
    input  logic [7:0]            cmd_ad,  // AL, AH, D0..D3
    input  logic                  cmd_stb, // high with AL only
    output logic                  wr_en,   // one cycle per full command
    output sensor_pkg::cmd_word_t wr_cmd   // valid with wr_en
);
    import sensor_pkg::*;

    localparam int CMD_BYTES = $bits(cmd_word_t) / 8; // six bytes
    localparam int CW        = $clog2(CMD_BYTES);

    logic [CW-1:0]          byte_cnt;  // 0 idle, else index of next byte
    logic [8*CMD_BYTES-1:0] sr;        // newest byte enters at the top
    logic                   last_byte; // D3 on the bus now

    // a fresh strobe always wins over an unfinished command
    assign last_byte = (byte_cnt == CW'(CMD_BYTES - 1)) && !cmd_stb;

    always_ff @(posedge mclk) begin
        if (rst) begin
            byte_cnt <= '0;
            wr_en    <= 1'b0;
        end else begin
            wr_en <= last_byte; // one cycle after D3 sampled
            if (cmd_stb) begin
                byte_cnt <= CW'(1); // AL taken, restart
            end else if (last_byte) begin
                byte_cnt <= '0;     // done, back to idle
            end else if (byte_cnt != '0) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // shift only while collecting, holds through the wr_en cycle
    always_ff @(posedge mclk) begin
        if (cmd_stb || (byte_cnt != '0)) begin
            sr <= {cmd_ad, sr[8*CMD_BYTES-1:8]};
        end
    end

    // after six shifts AL sits in the lowest byte
    assign wr_cmd = '{
        addr: sr[`SENS_ADDR_BITS-1:0],
        data: sr[8*CMD_BYTES-1:`SENS_ADDR_BITS]
    };

endmodule

/* src/sensor_ctrl_regs.sv */
`timescale 1ns/1ps
`include "sensor_config.svh"

module sensor_ctrl_regs #(
    parameter int CHN = 0 // channel index 0..3
) (
    input  logic                  mclk,
    input  logic                  rst,
    input  logic                  wr_en,    // from cmd_deser
    input  sensor_pkg::cmd_word_t wr_cmd,
    sensor_cfg_if.regs            cfg,      // to this channel's frame sync
    output logic [7:0]            st_ad,    // status address/data byte
    output logic                  st_rq,    // packet waiting
    input  logic                  st_start, // byte 0 accepted
    input  logic                  vact      // raw sensor vact for flags
);
    import sensor_pkg::*;

    localparam logic [15:0] CHN_BASE  = 16'(`SENS_GROUP_ADDR + CHN * `SENS_BASE_INC);
    localparam logic [15:0] MODE_ADDR = CHN_BASE + 16'(`SENS_MODE_RADDR);
    localparam logic [15:0] MULT_ADDR = CHN_BASE + 16'(`SENS_SYNC_MULT_RADDR);
    localparam logic [15:0] LATE_ADDR = CHN_BASE + 16'(`SENS_SYNC_LATE_RADDR);
    localparam logic [15:0] STAT_ADDR = CHN_BASE + 16'(`SENS_STATUS_RADDR);
    localparam logic [7:0]  ST_BYTE0  = 8'(`SENS_STATUS_BASE + `SENS_STATUS_INC * CHN);
    localparam int          SW        = $clog2(`SENS_STATUS_BYTES);

    cmd_data_u                  wdata;    // written word, mode or sync view
    cfg_t                       cfg_q;    // live configuration
    logic                       st_wr;    // status request write
    logic                       pend;     // request not yet accepted
    logic [SW-1:0]              seq;      // 0 idle, 1..3 tail bytes out
    logic [`SENS_SYNC_BITS-1:0] fn_cap;   // frame_num at start
    logic                       en_cap;   // chn_en at start
    logic                       vact_cap; // vact at start

    assign wdata    = wr_cmd.data;
    assign cfg.conf = cfg_q; // seen by frame sync the cycle after wr_en
    assign st_wr    = wr_en && (wr_cmd.addr == STAT_ADDR);

    always_ff @(posedge mclk) begin
        if (rst) begin
            cfg_q.chn_en     <= 1'b0;
            cfg_q.frame_mult <= '0;
            cfg_q.late_lines <= `SENS_SYNC_BITS'(`SENS_SYNC_LATE_DFLT);
        end else if (wr_en) begin
            case (wr_cmd.addr)
                MODE_ADDR: cfg_q.chn_en     <= wdata.mode.chn_en;  // bit 8 only
                MULT_ADDR: cfg_q.frame_mult <= wdata.sync.count;   // low half
                LATE_ADDR: cfg_q.late_lines <= wdata.sync.count;
                default:   cfg_q            <= cfg_q;              // other channel
            endcase
        end
    end

    // request and packet sequencing
    always_ff @(posedge mclk) begin
        if (rst) begin
            pend <= 1'b0;
            seq  <= '0;
        end else begin
            pend <= st_wr || (pend && !st_start); // repeat writes merge
            if (st_start) begin
                seq <= SW'(1);                    // byte 1 next cycle
            end else if (seq != '0) begin
                seq <= (seq == SW'(`SENS_STATUS_BYTES - 1)) ? '0 : seq + 1'b1;
            end
        end
    end

    // snapshot taken as byte 0 goes out
    always_ff @(posedge mclk) begin
        if (st_start) begin
            fn_cap   <= cfg.frame_num;
            en_cap   <= cfg_q.chn_en;
            vact_cap <= vact;
        end
    end

    // rq hidden while a packet tail is still going out
    assign st_rq = pend && (seq == '0);

    always_comb begin
        case (seq)
            SW'(1):  st_ad = fn_cap[7:0];             // frame_num low
            SW'(2):  st_ad = fn_cap[15:8];            // frame_num high
            SW'(3):  st_ad = {6'b0, en_cap, vact_cap}; // flags
            default: st_ad = ST_BYTE0;                // address byte
        endcase
    end

endmodule

/* src/sensor_frame_sync.sv */
`timescale 1ns/1ps
`include "sensor_config.svh"

module sensor_frame_sync (
    input  logic       mclk,
    input  logic       rst,
    sensor_cfg_if.sync cfg,      // config in, frame_num out
    input  logic       vact,     // sensor frame active
    input  logic       hact,     // sensor line active
    output logic       sof_out,  // combined frame start
    output logic       eof_out,  // combined frame end
    output logic       sof_late  // delayed start
);
    import sensor_pkg::*;

    localparam int SB = `SENS_SYNC_BITS;

    cfg_t          conf;      // local copy of channel config
    logic          vact_d;    // previous samples
    logic          hact_d;
    logic          v_rise;
    logic          v_fall;
    logic          h_fall;
    logic          active;    // inside a combined frame
    logic          armed;     // late pulse still owed
    logic [SB-1:0] sub_cnt;   // sensor frames done in this combined frame
    logic [SB-1:0] line_cnt;  // hact falls since sof
    logic [SB-1:0] line_nxt;
    logic [SB-1:0] frame_cnt; // output frames
    logic          frame_end; // last sensor frame of the group ends
    logic          late_hit;

    assign conf          = cfg.conf;
    assign cfg.frame_num = frame_cnt;

    assign v_rise    = vact && !vact_d;
    assign v_fall    = !vact && vact_d;
    assign h_fall    = !hact && hact_d;
    assign line_nxt  = line_cnt + 1'b1;
    // >= so a shrunk frame_mult still closes the frame
    assign frame_end = active && v_fall && (sub_cnt >= conf.frame_mult);
    // late sync forced out at eof if lines ran short
    assign late_hit  = armed && ((h_fall && (line_nxt == conf.late_lines)) || frame_end);

    always_ff @(posedge mclk) begin
        if (rst) begin
            vact_d    <= 1'b0;
            hact_d    <= 1'b0;
            active    <= 1'b0;
            armed     <= 1'b0;
            sub_cnt   <= '0;
            line_cnt  <= '0;
            frame_cnt <= '0;
            sof_out   <= 1'b0;
            eof_out   <= 1'b0;
            sof_late  <= 1'b0;
        end else begin
            vact_d   <= vact;
            hact_d   <= hact;
            sof_out  <= 1'b0; // single-cycle pulses
            eof_out  <= 1'b0;
            sof_late <= 1'b0;
            if (!conf.chn_en) begin
                active  <= 1'b0; // abort, no eof
                armed   <= 1'b0;
                sub_cnt <= '0;
            end else if (v_rise && !active) begin
                sof_out   <= 1'b1;
                active    <= 1'b1;
                sub_cnt   <= '0;
                line_cnt  <= '0;
                frame_cnt <= frame_cnt + 1'b1;
                armed     <= (conf.late_lines != '0);
                sof_late  <= (conf.late_lines == '0); // zero delay, with sof
            end else if (active) begin
                if (late_hit) begin
                    sof_late <= 1'b1;
                    armed    <= 1'b0; // once per combined frame
                end
                if (h_fall) begin
                    line_cnt <= line_nxt; // counts across sensor frames
                end
                if (frame_end) begin
                    eof_out <= 1'b1;
                    active  <= 1'b0;
                    sub_cnt <= '0;
                end else if (v_fall) begin
                    sub_cnt <= sub_cnt + 1'b1; // inner sensor frame done
                end
            end
        end
    end

endmodule

/* src/status_router4.sv */
`timescale 1ns/1ps
`include "sensor_config.svh"

module status_router4 (
    input  logic                              mclk,
    input  logic                              rst,
    input  logic [`SENS_NUM_CHN-1:0][7:0]     ad_in,       // per-channel bytes
    input  logic [`SENS_NUM_CHN-1:0]          rq_in,       // per-channel requests
    output logic [`SENS_NUM_CHN-1:0]          start_in,    // per-channel accept
    output logic [7:0]                        status_ad,   // merged byte stream
    output logic                              status_rq,   // merged request
    input  logic                              status_start // byte 0 accepted
);
    import sensor_pkg::*;

    localparam int NCH  = `SENS_NUM_CHN;
    localparam int CW   = $clog2(NCH);
    localparam int TW   = $clog2(`SENS_STATUS_BYTES);
    localparam int TAIL = `SENS_STATUS_BYTES - 1; // bytes after start

    logic [CW-1:0] sel;     // granted channel, also rr pointer
    logic [CW-1:0] pick;    // next requester after sel
    logic [CW-1:0] idx;
    logic          found;
    logic          locked;  // grant held, waiting or sending
    logic          sending; // start seen, tail bytes running
    logic [TW-1:0] tail;    // tail cycles left minus 1
    status_byte_t  ad_sel;

    // round robin, search starts just after the last grant
    always_comb begin
        pick  = sel;
        found = 1'b0;
        idx   = sel;
        for (int i = 1; i <= NCH; i++) begin
            idx = sel + CW'(i); // wraps, sel itself checked last
            if (!found && rq_in[idx]) begin
                pick  = idx;
                found = 1'b1;
            end
        end
    end

    assign ad_sel    = ad_in[sel];
    assign status_ad = ad_sel;
    assign status_rq = locked && rq_in[sel]; // channel drops rq after start

    // start goes to the granted channel alone
    always_comb begin
        start_in = '0;
        if (locked && !sending) begin
            start_in[sel] = status_start;
        end
    end

    always_ff @(posedge mclk) begin
        if (rst) begin
            sel     <= '0;
            locked  <= 1'b0;
            sending <= 1'b0;
            tail    <= '0;
        end else if (!locked) begin
            if (found) begin
                sel    <= pick;  // grant only between packets
                locked <= 1'b1;
            end
        end else if (!sending) begin
            if (status_start) begin
                sending <= 1'b1;
                tail    <= TW'(TAIL - 1);
            end
        end else if (tail == '0) begin
            locked  <= 1'b0; // last byte out, rearbitrate
            sending <= 1'b0;
        end else begin
            tail <= tail - 1'b1;
        end
    end

endmodule

/* src/sensors4_top.sv */
`timescale 1ns/1ps
`include "sensor_config.svh"

module sensors4_top (
    input  logic                     mclk,
    input  logic                     rst,
    input  logic [7:0]               cmd_ad,       // byte-serial commands
    input  logic                     cmd_stb,
    output logic [7:0]               status_ad,    // byte-serial status
    output logic                     status_rq,
    input  logic                     status_start,
    input  logic [`SENS_NUM_CHN-1:0] vact,         // one per sensor
    input  logic [`SENS_NUM_CHN-1:0] hact,
    output logic [`SENS_NUM_CHN-1:0] sof_out,
    output logic [`SENS_NUM_CHN-1:0] eof_out,
    output logic [`SENS_NUM_CHN-1:0] sof_late
);

    logic                             wr_en;    // shared write strobe
    sensor_pkg::cmd_word_t            wr_cmd;
    logic [`SENS_NUM_CHN-1:0][7:0]    st_ad;    // channel status bytes
    logic [`SENS_NUM_CHN-1:0]         st_rq;
    logic [`SENS_NUM_CHN-1:0]         st_start;

    cmd_deser u_cmd_deser (
        .mclk    (mclk),
        .rst     (rst),
        .cmd_ad  (cmd_ad),
        .cmd_stb (cmd_stb),
        .wr_en   (wr_en),
        .wr_cmd  (wr_cmd)
    );

    for (genvar i = 0; i < `SENS_NUM_CHN; i++) begin : g_chn
        sensor_cfg_if u_cfg ();

        sensor_ctrl_regs #(.CHN(i)) u_regs (
            .mclk (mclk), .rst (rst),
            .wr_en (wr_en), .wr_cmd (wr_cmd), .cfg (u_cfg),
            .st_ad (st_ad[i]), .st_rq (st_rq[i]), .st_start (st_start[i]),
            .vact (vact[i])
        );

        sensor_frame_sync u_sync (
            .mclk (mclk), .rst (rst), .cfg (u_cfg),
            .vact (vact[i]), .hact (hact[i]),
            .sof_out (sof_out[i]), .eof_out (eof_out[i]), .sof_late (sof_late[i])
        );
    end

    status_router4 u_router (
        .mclk (mclk), .rst (rst),
        .ad_in (st_ad), .rq_in (st_rq), .start_in (st_start),
        .status_ad (status_ad), .status_rq (status_rq), .status_start (status_start)
    );

endmodule

/* sim/sensors4_checker.sv */
`timescale 1ns/1ps
`include "sensor_config.svh"

module sensors4_checker (
    input logic                     mclk,
    input logic                     rst,
    input logic [`SENS_NUM_CHN-1:0] start_in,     // router to channels
    input logic                     status_rq,
    input logic                     status_start
);

    int fail_cnt = 0; // failed assertions so far

    // a start reaches exactly one granted channel
    a_start_onehot: assert property (@(posedge mclk) disable iff (rst)
        status_start |-> $onehot(start_in))
        else begin
            fail_cnt++;
            $error("status_start not routed to exactly one channel");
        end

    // start only taken against a live request
    a_start_with_rq: assert property (@(posedge mclk) disable iff (rst)
        status_start |-> status_rq)
        else begin
            fail_cnt++;
            $error("status_start accepted while status_rq low");
        end

    a_rq_held: assert property (@(posedge mclk) disable iff (rst)
        (status_rq && !status_start) |=> status_rq)
        else begin
            fail_cnt++;
            $error("status_rq dropped before status_start");
        end

endmodule

/* sim/sensors4_tb.sv */
`timescale 1ns/1ps
`include "sensor_config.svh"

module sensors4_tb;

    localparam logic [31:0] EN_WORD = 32'(1) << `SENS_CHN_EN_BIT; // mode word, enable only

    logic        mclk;
    logic        rst;
    logic [7:0]  cmd_ad;
    logic        cmd_stb;
    logic [7:0]  status_ad;
    logic        status_rq;
    logic        status_start;
    logic [`SENS_NUM_CHN-1:0] vact, hact, sof_out, eof_out, sof_late;

    int          sof_n[`SENS_NUM_CHN];      // pulse counters per channel
    int          eof_n[`SENS_NUM_CHN];
    int          late_n[`SENS_NUM_CHN];
    int          late_eof_n[`SENS_NUM_CHN]; // late coinciding with eof
    logic [31:0] pkt;                       // packet under collection, byte 0 lowest
    int          st_idx;                    // next byte index, 0 idle
    logic [31:0] pkts[$];                   // finished packets
    int          limit_cycles = 0;          // watchdog budget

    sensors4_top u_sensors4_top (
        .mclk (mclk), .rst (rst), .cmd_ad (cmd_ad), .cmd_stb (cmd_stb),
        .status_ad (status_ad), .status_rq (status_rq), .status_start (status_start),
        .vact (vact), .hact (hact),
        .sof_out (sof_out), .eof_out (eof_out), .sof_late (sof_late)
    );

    bind status_router4 sensors4_checker u_checker (
        .mclk (mclk), .rst (rst), .start_in (start_in),
        .status_rq (status_rq), .status_start (status_start)
    );

    always #50 mclk = ~mclk; // 100 ns period

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] expected, actual);
        if (expected !== actual) begin
            stop_on_error($sformatf("FAILED %s: expected 0x%0h, actual 0x%0h",
                                    name, expected, actual));
        end
    endtask

    // expected {sof, eof, late, late at eof} counts for whole sensor frames
    function automatic logic [63:0] exp_pulses(input int mult, late, lines, frames);
        int n;
        n = frames / (mult + 1);                   // combined frames
        return {16'(n), 16'(n), 16'(n),
                (late > lines * (mult + 1)) ? 16'(n) : 16'd0}; // lines ran out first
    endfunction

    // expected packet, byte 0 in the low bits
    function automatic logic [31:0] exp_packet(input int ch, fnum, input logic en, va);
        return {6'b0, en, va, 8'(fnum >> 8), 8'(fnum),
                8'(`SENS_STATUS_BASE + `SENS_STATUS_INC * ch)};
    endfunction

    task automatic write_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] bytes;
        bytes = {data, addr}; // AL first, D3 last
        for (int i = 0; i < 6; i++) begin
            @(posedge mclk);
            #1 cmd_stb = (i == 0);
            cmd_ad = bytes[8*i +: 8];
        end
        @(posedge mclk);
        #1 cmd_ad = 8'h00;
        repeat (2) @(posedge mclk); // config lands after wr_en
    endtask

    task automatic write_reg(input int ch, input int raddr, input logic [31:0] data);
        write_cmd(16'(`SENS_GROUP_ADDR + ch * `SENS_BASE_INC + raddr), data);
    endtask

    task automatic send_frame(input int ch, lines, len, gap);
        @(posedge mclk);
        #1 vact[ch] = 1'b1;
        repeat (2) @(posedge mclk);
        for (int l = 0; l < lines; l++) begin
            #1 hact[ch] = 1'b1;
            repeat (len) @(posedge mclk);
            #1 hact[ch] = 1'b0;
            repeat (2) @(posedge mclk); // horizontal blank
        end
        #1 vact[ch] = 1'b0;
        repeat (gap) @(posedge mclk);
    endtask

    // wait for a request, hold off start for gap cycles, then accept
    task automatic serve_status(input int gap);
        int waited;
        waited = 0;
        while (!status_rq) begin
            @(negedge mclk);
            waited++;
            if (waited > 64) begin
                stop_on_error("status_rq never rose after a status request");
            end
        end
        repeat (gap) @(posedge mclk);
        #1 status_start = 1'b1;
        @(posedge mclk);
        #1 status_start = 1'b0;
        repeat (`SENS_STATUS_BYTES) @(negedge mclk); // tail bytes collected
    endtask

    task automatic check_chn(input string name, input int ch, input logic [63:0] exp);
        check_eq({name, " sof count"}, exp[63:48], sof_n[ch]);
        check_eq({name, " eof count"}, exp[47:32], eof_n[ch]);
        check_eq({name, " late count"}, exp[31:16], late_n[ch]);
        check_eq({name, " late at eof"}, exp[15:0], late_eof_n[ch]);
    endtask

    task automatic check_packet(input string name, input logic [31:0] exp);
        check_eq({name, " packet present"}, 1, pkts.size() > 0);
        check_eq(name, exp, pkts.pop_front());
    endtask

    // compare process, outputs sampled mid-cycle
    always @(negedge mclk) begin
        if (!rst) begin
            if (u_sensors4_top.u_router.u_checker.fail_cnt != 0) begin
                stop_on_error("status router assertion failed");
            end
            for (int c = 0; c < `SENS_NUM_CHN; c++) begin
                if (sof_out[c]) sof_n[c]++;
                if (sof_late[c]) begin
                    late_n[c]++;
                    check_eq("late follows its sof", sof_n[c], late_n[c]);
                    if (eof_out[c]) late_eof_n[c]++;
                end
                if (eof_out[c]) begin
                    eof_n[c]++;
                    check_eq("eof follows its late", late_n[c], eof_n[c]);
                end
            end
            if (status_start) begin
                pkt[7:0] = status_ad; // address byte
                st_idx = 1;
            end else if (st_idx != 0) begin
                pkt[8*st_idx +: 8] = status_ad;
                st_idx++;
                if (st_idx == `SENS_STATUS_BYTES) begin
                    pkts.push_back(pkt);
                    st_idx = 0;
                end
            end
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge mclk);
        stop_on_error("timeout: tests did not finish within the frame schedule");
    end

    initial begin
        int lines, len, gap, late2, late4, frame_cyc;
        mclk = 1'b0;
        rst = 1'b1;
        cmd_ad = 8'h00;
        cmd_stb = 1'b0;
        status_start = 1'b0;
        vact = '0;
        hact = '0;
        st_idx = 0;
        void'($urandom(32'h47cbb911));
        lines = $urandom_range(10, 4);        // lines per sensor frame
        len = $urandom_range(6, 2);          // hact length
        gap = $urandom_range(8, 2);          // vertical blank
        late2 = $urandom_range(lines - 1, 1);
        late4 = lines + $urandom_range(5, 1); // past the last line
        frame_cyc = 4 + lines * (len + 2) + gap;
        limit_cycles = 15 * frame_cyc + 600; // 15 frames, commands and status
        repeat (8) @(posedge mclk);
        #1 rst = 1'b0;
        @(negedge mclk);
        check_eq("outputs after reset", 0, {status_rq, sof_out, eof_out, sof_late});

        send_frame(0, lines, len, gap); // channel 0 still disabled
        check_chn("disabled channel", 0, 64'd0);

        write_reg(2, `SENS_SYNC_LATE_RADDR, late2);
        write_reg(2, `SENS_MODE_RADDR, EN_WORD);
        repeat (3) send_frame(2, lines, len, gap);
        check_chn("single frames", 2, exp_pulses(0, late2, lines, 3));

        write_reg(1, `SENS_SYNC_MULT_RADDR, 2);
        write_reg(1, `SENS_MODE_RADDR, EN_WORD);
        repeat (9) send_frame(1, lines, len, gap);
        check_chn("combined frames", 1, exp_pulses(2, `SENS_SYNC_LATE_DFLT, lines, 9));
        write_reg(1, `SENS_STATUS_RADDR, 0);
        serve_status($urandom_range(8, 1));
        check_packet("channel 1 status", exp_packet(1, 3, 1'b1, 1'b0));

        write_reg(0, `SENS_SYNC_LATE_RADDR, late4);
        write_reg(0, `SENS_MODE_RADDR, EN_WORD);
        repeat (2) send_frame(0, lines, len, gap);
        check_chn("late past eof", 0, exp_pulses(0, late4, lines, 2));

        @(posedge mclk);
        #1 vact[3] = 1'b1; // flag bit seen on a disabled channel
        write_reg(0, `SENS_STATUS_RADDR, 0);
        write_reg(3, `SENS_STATUS_RADDR, 0);
        serve_status($urandom_range(12, 3)); // delayed start
        serve_status($urandom_range(12, 3));
        check_eq("packets collected", 2, pkts.size());
        check_packet("channel 0 status", exp_packet(0, 2, 1'b1, 1'b0));
        check_packet("channel 3 status", exp_packet(3, 0, 1'b0, 1'b1));
        @(posedge mclk);
        #1 vact[3] = 1'b0;
        repeat (4) @(posedge mclk);
        check_chn("idle channel", 3, 64'd0);

        if (u_sensors4_top.u_router.u_checker.fail_cnt == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            stop_on_error("status router assertions failed during the run");
        end
    end

endmodule

/* files.f */
+incdir+src
src/sensor_pkg.sv
src/sensor_cfg_if.sv
src/cmd_deser.sv
src/sensor_ctrl_regs.sv
src/sensor_frame_sync.sv
src/status_router4.sv
src/sensors4_top.sv
sim/sensors4_checker.sv
sim/sensors4_tb.sv

/* Bender.yml */
package:
  name: sensors4

sources:
  - include_dirs:
      - src
    files:
      - src/sensor_pkg.sv
      - src/sensor_cfg_if.sv
      - src/cmd_deser.sv
      - src/sensor_ctrl_regs.sv
      - src/sensor_frame_sync.sv
      - src/status_router4.sv
      - src/sensors4_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/sensors4_checker.sv
      - sim/sensors4_tb.sv
